// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - logic/core_pkg.sv
      - logic/bp_pkg.sv
      - logic/fetch_ctrl.sv
      - logic/fetch_buffer.sv
      - logic/bp_counter_update.sv
      - logic/bp_table_ram.sv
      - logic/fetch_top.sv
  - target: simulation
    files:
      - testbench/fetch_props.sv
      - testbench/fetch_tb.sv

// ==== flist.f ====
logic/core_pkg.sv
logic/bp_pkg.sv
logic/fetch_ctrl.sv
logic/fetch_buffer.sv
logic/bp_counter_update.sv
logic/bp_table_ram.sv
logic/fetch_top.sv
testbench/fetch_props.sv
testbench/fetch_tb.sv

// ==== logic/bp_counter_update.sv ====
`timescale 1ns/1ns

module bp_counter_update #(
        parameter int BP_ENTRIES = 1024
)
(
        input  logic                    i_wr_en,        // Strobe from fetch_ctrl.
        input  logic [31:0]             i_pc_from_alu,  // PC of resolved branch.
        input  bp_pkg::bp_state_t       i_taken,        // Old counter state.
        input  logic                    i_mispredict,   // Branch was mispredicted.

        output bp_pkg::bp_update_t      o_update,       // Address and new state.
        output logic                    o_wr            // Table write.
);

        localparam int idx_w = $clog2(BP_ENTRIES);

        // Next counter state.
        always_comb
        begin
                if (i_mispredict)
                begin
                        // Move toward the other direction.
                        case (i_taken)
                        bp_pkg::snt: o_update.data = bp_pkg::wnt;
                        bp_pkg::wnt: o_update.data = bp_pkg::wt;
                        bp_pkg::wt:  o_update.data = bp_pkg::wnt;
                        default:     o_update.data = bp_pkg::wt;
                        endcase
                end
                else
                begin
                        // Confirmed, saturate on the current side.
                        case (i_taken)
                        bp_pkg::snt,
                        bp_pkg::wnt: o_update.data = bp_pkg::snt;
                        default:     o_update.data = bp_pkg::st;
                        endcase
                end
        end

        // Index skips bit 0, halfword aligned PCs.
        always_comb
        begin
                o_update.addr            = '0;
                o_update.addr[idx_w-1:0] = i_pc_from_alu[idx_w:1];
        end

        assign o_wr = i_wr_en;

endmodule

// ==== logic/bp_pkg.sv ====
package bp_pkg;

        // Two-bit saturating counter states.
        typedef enum logic [1:0] {
                snt = 2'd0,     // Strongly not taken.
                wnt = 2'd1,     // Weakly not taken.
                wt  = 2'd2,     // Weakly taken.
                st  = 2'd3      // Strongly taken.
        } bp_state_t;

        // Widest table index the update struct can carry.
        // Real index width comes from BP_ENTRIES per module.
        localparam int bp_addr_max_w = 16;

        // One write into the counter table.
        typedef struct packed {
                logic [bp_addr_max_w-1:0] addr;        // Zero extended index.
                bp_state_t                data;        // New counter value.
        } bp_update_t;

endpackage

// ==== logic/bp_table_ram.sv ====
`timescale 1ns/1ns

module bp_table_ram #(
        parameter int BP_ENTRIES = 1024
)
(
        input  logic                    i_clk,
        input  logic                    i_wr,           // Write strobe.
        input  bp_pkg::bp_update_t      i_update,       // Write address and data.
        input  logic [31:0]             i_rd_pc,        // Read side PC.
        output logic [1:0]              o_rd_data       // Registered read.
);

        localparam int idx_w = $clog2(BP_ENTRIES);

        // Counter storage, no reset.
        logic [1:0] mem [BP_ENTRIES];

        logic [idx_w-1:0] rd_idx;
        logic [idx_w-1:0] wr_idx;

        assign rd_idx = i_rd_pc[idx_w:1];
        assign wr_idx = i_update.addr[idx_w-1:0];

        // Read and write in one block.
        // Same address read sees the old value.
        always_ff @(posedge i_clk)
        begin
                if (i_wr)
                        mem[wr_idx] <= i_update.data;
                o_rd_data <= mem[rd_idx];
        end

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

        // What the fetch buffer does in a given cycle.
        typedef enum logic [1:0] {
                act_clear = 2'd0,       // Drop valid and abort.
                act_hold  = 2'd1,       // Freeze everything.
                act_load  = 2'd2,       // Take a new instruction slot.
                act_idle  = 2'd3        // Nothing new, valid drops.
        } fetch_action_t;

        // Fetch stage result handed to decode.
        typedef struct packed {
                logic        valid;             // Slot holds an instruction.
                logic        instr_abort;       // Slot carries an abort.
                logic [31:0] pc;                // PC of the slot.
                logic [31:0] pc_plus_8;         // Read-ahead PC.
        } fetch_out_t;

        // Clear and stall requests from later stages.
        // Field order follows priority, highest first.
        typedef struct packed {
                logic clear_wb;         // Writeback flush.
                logic data_stall;       // Data cache busy.
                logic clear_alu;        // Branch mispredict flush.
                logic stall_shifter;    // Shifter busy.
                logic stall_issue;      // Issue busy.
                logic stall_decode;     // Decode busy.
                logic clear_decode;     // Decode flush.
        } pipe_req_t;

        // Thumb bit position in the status register.
        localparam int cpsr_t_bit = 5;

        // Read-ahead offsets for the two instruction sets.
        localparam logic [31:0] arm_ahead   = 32'd8;
        localparam logic [31:0] thumb_ahead = 32'd4;

        // Reset value of the read-ahead PC.
        localparam logic [31:0] reset_pc_plus_8 = 32'd8;

endpackage

// ==== logic/fetch_buffer.sv ====
`timescale 1ns/1ns

module fetch_buffer
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  core_pkg::fetch_action_t i_action,       // From fetch_ctrl.

        input  logic [31:0]             i_pc,           // Current PC.
        input  logic [31:0]             i_cpsr,         // Status register.

        input  logic                    i_instr_abort,  // Abort from cache.
        input  logic [31:0]             i_instruction,  // Word from cache.

        output core_pkg::fetch_out_t    o_fetch,        // Registered slot.
        output logic [31:0]             o_instruction   // Same cycle word.
);

        logic [31:0] read_ahead;        // PC+4 or PC+8.

        // Thumb state reads ahead by one halfword pair.
        always_comb
        begin
                if (i_cpsr[core_pkg::cpsr_t_bit])
                        read_ahead = i_pc + core_pkg::thumb_ahead;
                else
                        read_ahead = i_pc + core_pkg::arm_ahead;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_fetch.valid       <= 1'b0;
                        o_fetch.instr_abort <= 1'b0;
                        o_fetch.pc          <= 32'd0;
                        o_fetch.pc_plus_8   <= core_pkg::reset_pc_plus_8;
                end
                else
                begin
                        case (i_action)
                        core_pkg::act_clear:
                        begin
                                o_fetch.valid       <= 1'b0;
                                o_fetch.instr_abort <= 1'b0;
                        end
                        core_pkg::act_load:
                        begin
                                // Aborts arrive as valid slots.
                                o_fetch.valid       <= 1'b1;
                                o_fetch.instr_abort <= i_instr_abort;
                                o_fetch.pc          <= i_pc;
                                o_fetch.pc_plus_8   <= read_ahead;
                        end
                        core_pkg::act_idle:
                        begin
                                o_fetch.valid       <= 1'b0;     // Abort flag kept.
                        end
                        default:
                        begin
                                // Hold keeps the slot untouched.
                        end
                        endcase
                end
        end

        // Cache handles its own stalls, word goes straight on.
        assign o_instruction = i_instruction;

endmodule

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  core_pkg::pipe_req_t     i_pipe,         // Clear and stall requests.

        input  logic                    i_valid,        // Cache word valid.
        input  logic                    i_instr_abort,  // Cache reports an abort.
        input  logic                    i_confirm,      // ALU confirms a prediction.

        output core_pkg::fetch_action_t o_action,       // Buffer action this cycle.
        output logic                    o_bp_wr_en      // Predictor write strobe.
);

        // Set once an aborted slot has been loaded.
        // Only a clear brings the unit back.
        logic sleep_ff;
        logic sleep_nxt;

        logic any_stall;        // Low priority stalls merged.

        assign any_stall = i_pipe.stall_shifter |
                           i_pipe.stall_issue   |
                           i_pipe.stall_decode;

        // Fixed priority chain.
        always_comb
        begin
                o_action  = core_pkg::act_idle;         // Default drops valid only.
                sleep_nxt = sleep_ff;

                if (i_pipe.clear_wb)
                begin
                        o_action  = core_pkg::act_clear;
                        sleep_nxt = 1'b0;               // Wake up.
                end
                else if (i_pipe.data_stall)
                begin
                        o_action  = core_pkg::act_hold;
                end
                else if (i_pipe.clear_alu)
                begin
                        o_action  = core_pkg::act_clear;
                        sleep_nxt = 1'b0;               // Wake up.
                end
                else if (any_stall)
                begin
                        o_action  = core_pkg::act_hold;
                end
                else if (i_pipe.clear_decode)
                begin
                        o_action  = core_pkg::act_clear;
                        sleep_nxt = 1'b0;
                end
                else if (sleep_ff)
                begin
                        // Keep output empty while asleep.
                        o_action  = core_pkg::act_clear;
                end
                else if (i_valid)
                begin
                        o_action  = core_pkg::act_load;
                        if (i_instr_abort)
                                sleep_nxt = 1'b1;       // Abort puts unit to sleep.
                end
        end

        // Predictor writes are blocked while data side stalls.
        assign o_bp_wr_en = ~i_pipe.data_stall & (i_pipe.clear_alu | i_confirm);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        sleep_ff <= 1'b0;
                else
                        sleep_ff <= sleep_nxt;
        end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top #(
        parameter int BP_ENTRIES = 1024
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  core_pkg::pipe_req_t     i_pipe,                 // Clear and stall requests.

        input  logic [31:0]             i_pc,                   // From writeback.
        input  logic [31:0]             i_cpsr,                 // Status register.

        input  logic [31:0]             i_instruction,          // Cache word.
        input  logic                    i_valid,                // Cache word valid.
        input  logic                    i_instr_abort,          // Cache abort.

        input  logic                    i_confirm_from_alu,     // Prediction confirmed.
        input  logic [31:0]             i_pc_from_alu,          // Resolved branch PC.
        input  logic [1:0]              i_taken,                // Old counter state.

        output core_pkg::fetch_out_t    o_fetch,                // To decode.
        output logic [31:0]             o_instruction,          // To decode.
        output logic [1:0]              o_taken                 // Prediction for i_pc.
);

        core_pkg::fetch_action_t        action;
        logic                           bp_wr_en;
        bp_pkg::bp_update_t             bp_update;
        logic                           bp_wr;
        bp_pkg::bp_state_t              taken_state;

        assign taken_state = bp_pkg::bp_state_t'(i_taken);

        fetch_ctrl u_fetch_ctrl
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_pipe         (i_pipe),
                .i_valid        (i_valid),
                .i_instr_abort  (i_instr_abort),
                .i_confirm      (i_confirm_from_alu),
                .o_action       (action),
                .o_bp_wr_en     (bp_wr_en)
        );

        fetch_buffer u_fetch_buffer
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_action       (action),
                .i_pc           (i_pc),
                .i_cpsr         (i_cpsr),
                .i_instr_abort  (i_instr_abort),
                .i_instruction  (i_instruction),
                .o_fetch        (o_fetch),
                .o_instruction  (o_instruction)
        );

        // Mispredict rides on the ALU clear.
        bp_counter_update #(.BP_ENTRIES(BP_ENTRIES)) u_bp_counter_update
        (
                .i_wr_en        (bp_wr_en),
                .i_pc_from_alu  (i_pc_from_alu),
                .i_taken        (taken_state),
                .i_mispredict   (i_pipe.clear_alu),
                .o_update       (bp_update),
                .o_wr           (bp_wr)
        );

        bp_table_ram #(.BP_ENTRIES(BP_ENTRIES)) u_bp_table_ram
        (
                .i_clk          (i_clk),
                .i_wr           (bp_wr),
                .i_update       (bp_update),
                .i_rd_pc        (i_pc),
                .o_rd_data      (o_taken)
        );

endmodule

// ==== testbench/fetch_props.sv ====
`timescale 1ns/1ns

module fetch_props
(
        input logic                     i_clk,
        input logic                     i_reset,
        input core_pkg::fetch_action_t  i_action,       // Buffer action.
        input logic                     i_sleep,        // Abort sleep flag.
        input core_pkg::fetch_out_t     i_fetch         // Registered slot.
);

        // Reset leaves an empty slot.
        a_reset_valid: assert property (@(posedge i_clk) i_reset |=> !i_fetch.valid)
                else $error("o_fetch.valid high after a reset cycle");

        // Hold freezes the whole slot.
        a_hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
                i_action == core_pkg::act_hold |=> $stable(i_fetch))
                else $error("o_fetch changed during a hold");

        a_clear_drops: assert property (@(posedge i_clk) disable iff (i_reset)
                i_action == core_pkg::act_clear |=> !i_fetch.valid)
                else $error("o_fetch.valid high after a clear");

        // Asleep, the slot either empties or stays frozen.
        a_sleep_no_valid: assert property (@(posedge i_clk) disable iff (i_reset)
                i_sleep |=> !i_fetch.valid || $stable(i_fetch))
                else $error("new valid slot while asleep");

endmodule

bind fetch_top fetch_props u_fetch_props
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_action       (action),
        .i_sleep        (u_fetch_ctrl.sleep_ff),
        .i_fetch        (o_fetch)
);

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

        localparam int bp_entries = 1024;
        localparam int idx_w      = 10;         // log2 of bp_entries.
        localparam int max_wait   = 20;         // Cycles before a wait gives up.

        // Expected state carried from one edge to the next.
        typedef struct packed {
                core_pkg::fetch_out_t fetch;
                logic                 sleep;    // Abort sleep flag.
                logic [1:0]           counter;  // Next predictor value.
        } ref_t;

        logic                   i_clk;
        logic                   i_reset;
        core_pkg::pipe_req_t    i_pipe;
        logic [31:0]            i_pc;
        logic [31:0]            i_cpsr;
        logic [31:0]            i_instruction;
        logic                   i_valid;
        logic                   i_instr_abort;
        logic                   i_confirm_from_alu;
        logic [31:0]            i_pc_from_alu;
        logic [1:0]             i_taken;
        core_pkg::fetch_out_t   o_fetch;
        logic [31:0]            o_instruction;
        logic [1:0]             o_taken;

        integer seed;
        int     errors = 0;
        int     checks = 0;

        ref_t           model;
        ref_t           step;
        logic           model_known = 1'b0;     // Set by the first reset edge.
        logic [1:0]     shadow [bp_entries];    // Shadow predictor table.
        logic           shadow_known [bp_entries];
        logic [1:0]     exp_taken;
        logic           exp_taken_known = 1'b0;

        fetch_top #(.BP_ENTRIES(bp_entries)) i_fetch_top
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_pipe                 (i_pipe),
                .i_pc                   (i_pc),
                .i_cpsr                 (i_cpsr),
                .i_instruction          (i_instruction),
                .i_valid                (i_valid),
                .i_instr_abort          (i_instr_abort),
                .i_confirm_from_alu     (i_confirm_from_alu),
                .i_pc_from_alu          (i_pc_from_alu),
                .i_taken                (i_taken),
                .o_fetch                (o_fetch),
                .o_instruction          (o_instruction),
                .o_taken                (o_taken)
        );

        initial
        begin
                i_clk = 1'b0;
                forever
                        #50 i_clk = ~i_clk;     // 100 ns period.
        end

        // Next fetch slot, sleep flag and counter value for one clock edge.
        function automatic ref_t ref_step(input ref_t cur, input core_pkg::pipe_req_t pipe,
                                          input logic valid, input logic abort,
                                          input logic [31:0] pc, input logic [31:0] cpsr,
                                          input logic [1:0] old_state);
                ref_t nxt;
                logic hold;
                logic clear;
                nxt   = cur;
                // Stalls only lose to clears ranked above them.
                hold  = ~pipe.clear_wb & (pipe.data_stall | (~pipe.clear_alu &
                        (pipe.stall_shifter | pipe.stall_issue | pipe.stall_decode)));
                clear = ~hold & (pipe.clear_wb | pipe.clear_alu | pipe.clear_decode);
                if (hold)
                        nxt.fetch = cur.fetch;          // Slot frozen.
                else if (clear || cur.sleep)
                begin
                        nxt.fetch.valid       = 1'b0;
                        nxt.fetch.instr_abort = 1'b0;
                        if (clear)
                                nxt.sleep = 1'b0;       // Any clear wakes.
                end
                else if (valid)
                begin
                        nxt.fetch.valid       = 1'b1;
                        nxt.fetch.instr_abort = abort;
                        nxt.fetch.pc          = pc;
                        nxt.fetch.pc_plus_8   = cpsr[core_pkg::cpsr_t_bit] ? pc + 32'd4 : pc + 32'd8;
                        nxt.sleep             = abort;
                end
                else
                        nxt.fetch.valid = 1'b0;         // Idle keeps the rest.
                // Mispredict comes in on clear_alu.
                case ({pipe.clear_alu, old_state})
                3'b1_00: nxt.counter = bp_pkg::wnt;
                3'b1_01: nxt.counter = bp_pkg::wt;
                3'b1_10: nxt.counter = bp_pkg::wnt;
                3'b1_11: nxt.counter = bp_pkg::wt;
                default: nxt.counter = old_state[1] ? bp_pkg::st : bp_pkg::snt;
                endcase
                return nxt;
        endfunction

        task automatic compare_value(input string name, input logic [65:0] got,
                                     input logic [65:0] exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
                end
        endtask

        // Steps on falling edges until a valid slot with the given abort flag shows.
        task automatic wait_fetch_valid(input logic want_abort);
                int n;
                for (n = 0; n < max_wait; n++)
                begin
                        if (o_fetch.valid === 1'b1 && o_fetch.instr_abort === want_abort)
                                break;
                        @(negedge i_clk);
                end
                if (n == max_wait)
                begin
                        errors++;
                        $display("timeout waiting for a valid fetch slot, abort %b", want_abort);
                        $display("checks %0d errors %0d", checks, errors);
                        $display("Some tests failed");
                        $finish;
                end
        endtask

        // Compare first, then advance the model with the inputs of this edge.
        always @(posedge i_clk)
        begin
                if (model_known)
                        compare_value("o_fetch", o_fetch, model.fetch);
                if (exp_taken_known)
                        compare_value("o_taken", o_taken, exp_taken);
                compare_value("o_instruction", o_instruction, i_instruction);
                step = ref_step(model, i_pipe, i_valid, i_instr_abort, i_pc, i_cpsr, i_taken);
                if (i_reset)
                begin
                        model.fetch = {1'b0, 1'b0, 32'd0, 32'd8};
                        model.sleep = 1'b0;
                        model_known = 1'b1;
                end
                else
                        model = step;
                exp_taken       = shadow[i_pc[idx_w:1]];        // Old data on a collision.
                exp_taken_known = shadow_known[i_pc[idx_w:1]];
                if (!i_pipe.data_stall && (i_pipe.clear_alu || i_confirm_from_alu))
                begin
                        shadow[i_pc_from_alu[idx_w:1]]       = step.counter;
                        shadow_known[i_pc_from_alu[idx_w:1]] = 1'b1;
                end
        end

        initial
        begin
                int n;
                int k;
                logic [31:0] wr_pc;
                seed               = 28882;
                i_reset            = 1'b1;
                i_pipe             = '0;
                i_pc               = 32'd0;
                i_cpsr             = 32'd0;
                i_instruction      = 32'd0;
                i_valid            = 1'b0;
                i_instr_abort      = 1'b0;
                i_confirm_from_alu = 1'b0;
                i_pc_from_alu      = 32'd0;
                i_taken            = 2'd0;
                wr_pc              = 32'd0;
                for (k = 0; k < bp_entries; k++)
                        shadow_known[k] = 1'b0;         // Table has no reset.
                repeat (2) @(negedge i_clk);
                i_reset = 1'b0;
                compare_value("o_fetch after reset", o_fetch, {1'b0, 1'b0, 32'd0, 32'd8});

                // Plain loads, ARM and Thumb mixed by the random status word.
                for (n = 0; n < 24; n++)
                begin
                        i_pc          = $random(seed);
                        i_cpsr        = $random(seed);
                        i_instruction = $random(seed);
                        i_valid       = 1'b1;
                        @(negedge i_clk);
                end
                wait_fetch_valid(1'b0);

                // Random clear and stall mixes, with predictor traffic.
                for (n = 0; n < 60; n++)
                begin
                        i_pipe             = core_pkg::pipe_req_t'(7'($random(seed) &
                                                                   $random(seed) & $random(seed)));
                        i_valid            = 1'($random(seed));
                        i_instr_abort      = (($random(seed) & 7) == 0);
                        i_pc               = $random(seed);
                        i_cpsr             = $random(seed);
                        i_instruction      = $random(seed);
                        i_confirm_from_alu = 1'($random(seed));
                        i_pc_from_alu      = $random(seed);
                        i_taken            = 2'($random(seed));
                        @(negedge i_clk);
                end
                i_pipe             = '0;
                i_pipe.clear_wb    = 1'b1;      // Wake if asleep.
                i_valid            = 1'b0;
                i_instr_abort      = 1'b0;
                i_confirm_from_alu = 1'b0;
                @(negedge i_clk);
                i_pipe = '0;

                // Abort then sleep until a clear.
                i_valid       = 1'b1;
                i_instr_abort = 1'b1;
                i_pc          = $random(seed);
                @(negedge i_clk);
                wait_fetch_valid(1'b1);
                i_instr_abort = 1'b0;
                for (n = 0; n < 4; n++)
                begin
                        i_pc = $random(seed);   // Ignored while asleep.
                        @(negedge i_clk);
                end
                i_pipe.clear_decode = 1'b1;
                @(negedge i_clk);
                i_pipe = '0;
                i_pc   = $random(seed);
                @(negedge i_clk);
                wait_fetch_valid(1'b0);
                i_valid = 1'b0;

                // Counter writes, then read back the same entry.
                for (n = 0; n < 16; n++)
                begin
                        wr_pc              = $random(seed);
                        i_pipe             = '0;
                        i_pipe.clear_alu   = 1'($random(seed));
                        i_confirm_from_alu = ~i_pipe.clear_alu;
                        i_pc_from_alu      = wr_pc;
                        i_taken            = 2'($random(seed));
                        i_pc               = wr_pc;     // Same cycle read.
                        @(negedge i_clk);
                        i_pipe             = '0;
                        i_confirm_from_alu = 1'b0;
                        @(negedge i_clk);
                end

                // Write blocked by data_stall.
                i_pipe.data_stall  = 1'b1;
                i_pipe.clear_alu   = 1'b1;
                i_confirm_from_alu = 1'b1;
                i_pc_from_alu      = wr_pc;
                // Old state whose mispredict update differs from the stored entry.
                i_taken            = (shadow[wr_pc[idx_w:1]] == bp_pkg::wt) ? bp_pkg::snt
                                                                             : bp_pkg::wnt;
                @(negedge i_clk);
                i_pipe             = '0;
                i_confirm_from_alu = 1'b0;
                repeat (2) @(negedge i_clk);
                compare_value("o_taken after stalled write", o_taken, shadow[wr_pc[idx_w:1]]);

                repeat (2) @(negedge i_clk);
                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0)
                        $display("All tests passed");
                else
                        $display("Some tests failed");
                $finish;
        end

endmodule
